/* hdl/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// cache geometry
`define LSU_WAY_CNT 2
`define LSU_IDX_LEN 8
`define LSU_TAG_LEN 22

// m2 op codes
`define LSU_OP_READ  2'd0
`define LSU_OP_WRITE 2'd1
`define LSU_OP_INV   2'd2

`endif

/* hdl/lsu_pkg.sv */
`include "lsu_settings.svh"

package lsu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  strobe_t;
  typedef logic [`LSU_IDX_LEN-1:0] idx_t;

  // valid bit on top of the physical tag
  typedef logic [`LSU_TAG_LEN:0] tag_t;

  typedef logic [`LSU_WAY_CNT-1:0] way_t;
  typedef logic [1:0] op_t;

  typedef enum logic [2:0] {
    LD_LB,
    LD_LBU,
    LD_LH,
    LD_LHU,
    LD_LW
  } load_type_e;

  // m2 sequencing in the read port
  typedef enum logic [2:0] {
    S_NORMAL,
    S_REFILL_READ,
    S_UNCACHE_READ,
    S_WRITE,
    S_INVOP,
    S_WAIT_STALL
  } rport_state_e;

endpackage

/* hdl/lsu_wport_if.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

interface lsu_wport_if import lsu_pkg::*; ();

  // request levels from the read port
  logic    refill_req;
  logic    uncached_read_req;
  logic    write_req;
  logic    write_hit;
  logic    inv_req;
  addr_t   req_addr;
  word_t   req_wdata;
  strobe_t req_strobe;
  way_t    req_wsel;

  // ram writes, all owned by the write port
  strobe_t [`LSU_WAY_CNT-1:0] data_we;
  idx_t    data_waddr;
  word_t   data_wdata;
  way_t    tag_we;
  idx_t    tag_waddr;
  tag_t    tag_wdata;

  logic    read_ready;
  word_t   rdata;
  logic    uop_ready;

  modport rport (
    output refill_req, uncached_read_req, write_req, write_hit, inv_req,
    output req_addr, req_wdata, req_strobe, req_wsel,
    input  data_we, data_waddr, data_wdata, tag_we, tag_waddr, tag_wdata,
    input  read_ready, rdata, uop_ready
  );

  modport wport (
    input  refill_req, uncached_read_req, write_req, write_hit, inv_req,
    input  req_addr, req_wdata, req_strobe, req_wsel,
    output data_we, data_waddr, data_wdata, tag_we, tag_waddr, tag_wdata,
    output read_ready, rdata, uop_ready
  );

endinterface

/* hdl/sdp_ram.sv */
`timescale 1ns/1ps

module sdp_ram import lsu_pkg::*; #(
  parameter int DATA_W = 32,
  parameter int BE_W   = 4
) (
  input  logic              clk,
  input  logic [BE_W-1:0]   we_i,
  input  idx_t              waddr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  idx_t              raddr_i,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int LANE_W = DATA_W / BE_W;
  localparam int DEPTH  = 2 ** $bits(idx_t);

  logic [DATA_W-1:0] mem [0:DEPTH-1];

  // read before write, same-address reads see the old entry
  always_ff @(posedge clk) begin
    for (int b = 0; b < BE_W; b++) begin
      if (we_i[b]) begin
        mem[waddr_i][b*LANE_W +: LANE_W] <= wdata_i[b*LANE_W +: LANE_W];
      end
    end
    rdata_o <= mem[raddr_i];
  end

endmodule

/* hdl/dcache_rport.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module dcache_rport import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  addr_t      ex_vaddr_i,
  input  addr_t      m1_vaddr_i,
  input  addr_t      m1_paddr_i,
  input  logic       m1_uncached_i,
  input  logic       m1_stall_i,
  input  addr_t      m2_vaddr_i,
  input  addr_t      m2_paddr_i,
  input  word_t      m2_wdata_i,
  input  strobe_t    m2_strobe_i,
  input  load_type_e m2_type_i,
  input  op_t        m2_op_i,
  input  logic       m2_valid_i,
  input  logic       m2_uncached_i,
  input  logic       m2_stall_i,
  output logic       m2_busy_o,
  output word_t      m2_rdata_o,
  output logic       m2_rvalid_o,
  lsu_wport_if.rport wp
);

  localparam int WAYS = `LSU_WAY_CNT;

  function automatic logic tag_match(tag_t t, addr_t pa);
    return t[`LSU_TAG_LEN] && (t[`LSU_TAG_LEN-1:0] == pa[31:32-`LSU_TAG_LEN]);
  endfunction

  function automatic word_t fmt_load(word_t w, logic [1:0] off, load_type_e t);
    word_t s;
    s = w >> {off, 3'b000};
    case (t)
      LD_LB:   fmt_load = {{24{s[7]}}, s[7:0]};
      LD_LBU:  fmt_load = {24'b0, s[7:0]};
      LD_LH:   fmt_load = {{16{s[15]}}, s[15:0]};
      LD_LHU:  fmt_load = {16'b0, s[15:0]};
      default: fmt_load = w;
    endcase
  endfunction

  idx_t ex_idx, m1_idx, m2_idx;
  assign ex_idx = ex_vaddr_i[`LSU_IDX_LEN+1:2];
  assign m1_idx = m1_vaddr_i[`LSU_IDX_LEN+1:2];
  assign m2_idx = m2_vaddr_i[`LSU_IDX_LEN+1:2];

  word_t [WAYS-1:0] raw_data, m1_data, m1_data_q, m2_data_q;
  tag_t  [WAYS-1:0] raw_tag, m1_tag, m1_tag_q;
  way_t             m1_hit, m2_hit_q;

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    sdp_ram #(.DATA_W(32), .BE_W(4)) u_data_ram (
      .clk     (clk),
      .we_i    (wp.data_we[w]),
      .waddr_i (wp.data_waddr),
      .wdata_i (wp.data_wdata),
      .raddr_i (ex_idx),
      .rdata_o (raw_data[w])
    );
    sdp_ram #(.DATA_W($bits(tag_t)), .BE_W(1)) u_tag_ram (
      .clk     (clk),
      .we_i    (wp.tag_we[w]),
      .waddr_i (wp.tag_waddr),
      .wdata_i (wp.tag_wdata),
      .raddr_i (ex_idx),
      .rdata_o (raw_tag[w])
    );
  end

  // write seen one cycle ago, the ram read in ex missed it
  strobe_t [WAYS-1:0] wb_data_we;
  idx_t               wb_data_waddr, wb_tag_waddr;
  word_t              wb_data_wdata;
  way_t               wb_tag_we;
  tag_t               wb_tag_wdata;
  logic               m1_stall_q;

  always_ff @(posedge clk) begin
    wb_data_we    <= wp.data_we;
    wb_data_waddr <= wp.data_waddr;
    wb_data_wdata <= wp.data_wdata;
    wb_tag_we     <= wp.tag_we;
    wb_tag_waddr  <= wp.tag_waddr;
    wb_tag_wdata  <= wp.tag_wdata;
    m1_data_q     <= m1_data;
    m1_tag_q      <= m1_tag;
    m1_stall_q    <= rst_n ? m1_stall_i : 1'b0;
  end

  // m1 snoop, newest write wins
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      m1_data[w] = m1_stall_q ? m1_data_q[w] : raw_data[w];
      m1_tag[w]  = m1_stall_q ? m1_tag_q[w] : raw_tag[w];
      for (int b = 0; b < 4; b++) begin
        if (wb_data_we[w][b] && wb_data_waddr == m1_idx) begin
          m1_data[w][8*b +: 8] = wb_data_wdata[8*b +: 8];
        end
        if (wp.data_we[w][b] && wp.data_waddr == m1_idx) begin
          m1_data[w][8*b +: 8] = wp.data_wdata[8*b +: 8];
        end
      end
      if (wb_tag_we[w] && wb_tag_waddr == m1_idx) begin
        m1_tag[w] = wb_tag_wdata;
      end
      if (wp.tag_we[w] && wp.tag_waddr == m1_idx) begin
        m1_tag[w] = wp.tag_wdata;
      end
      m1_hit[w] = tag_match(m1_tag[w], m1_paddr_i) && !m1_uncached_i;
    end
  end

  rport_state_e fsm_q, fsm_d;
  logic         m2_hold;
  word_t        fill_q, merged;

  assign m2_hold = m2_stall_i || m2_busy_o;

  // m2 copy, absorbs write-port writes while held
  always_ff @(posedge clk) begin
    if (!m2_hold) begin
      m2_data_q <= m1_data;
      m2_hit_q  <= m1_hit;
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        for (int b = 0; b < 4; b++) begin
          if (wp.data_we[w][b] && wp.data_waddr == m2_idx) begin
            m2_data_q[w][8*b +: 8] <= wp.data_wdata[8*b +: 8];
          end
        end
        if (wp.tag_we[w] && wp.tag_waddr == m2_idx) begin
          m2_hit_q[w] <= tag_match(wp.tag_wdata, m2_paddr_i) && !m2_uncached_i;
        end
      end
    end
  end

  // refill or uncached word, dropped once m2 moves on
  always_ff @(posedge clk) begin
    if (wp.read_ready) begin
      fill_q <= wp.rdata;
    end else if (!m2_hold) begin
      fill_q <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fsm_q <= S_NORMAL;
    end else begin
      fsm_q <= fsm_d;
    end
  end

  always_comb begin
    fsm_d     = fsm_q;
    m2_busy_o = 1'b0;
    case (fsm_q)
      S_NORMAL: begin
        if (m2_valid_i) begin
          if (m2_op_i == `LSU_OP_READ) begin
            if (m2_uncached_i) begin
              fsm_d     = S_UNCACHE_READ;
              m2_busy_o = 1'b1;
            end else if (!(|m2_hit_q)) begin
              fsm_d     = S_REFILL_READ;
              m2_busy_o = 1'b1;
            end
          end else if (m2_op_i == `LSU_OP_WRITE) begin
            // every store goes out to memory
            fsm_d     = S_WRITE;
            m2_busy_o = 1'b1;
          end else if (m2_op_i == `LSU_OP_INV) begin
            fsm_d     = S_INVOP;
            m2_busy_o = 1'b1;
          end
        end
      end
      S_REFILL_READ: begin
        m2_busy_o = 1'b1;
        if (wp.uop_ready) begin
          fsm_d = S_WAIT_STALL;
        end
      end
      S_UNCACHE_READ: begin
        m2_busy_o = 1'b1;
        if (wp.read_ready) begin
          fsm_d = S_WAIT_STALL;
        end
      end
      S_WRITE, S_INVOP: begin
        m2_busy_o = 1'b1;
        if (wp.uop_ready) begin
          fsm_d = S_WAIT_STALL;
        end
      end
      S_WAIT_STALL: begin
        if (!m2_stall_i) begin
          fsm_d = S_NORMAL;
        end
      end
      default: fsm_d = S_NORMAL;
    endcase
  end

  always_comb begin
    merged = fill_q;
    for (int w = 0; w < WAYS; w++) begin
      if (m2_hit_q[w]) begin
        merged = merged | m2_data_q[w];
      end
    end
  end

  assign m2_rdata_o  = fmt_load(merged, m2_vaddr_i[1:0], m2_type_i);
  // cached hit in the first m2 cycle, or the word held after a miss sequence
  assign m2_rvalid_o = m2_valid_i && (m2_op_i == `LSU_OP_READ) &&
                       ((fsm_q == S_NORMAL && !m2_uncached_i && (|m2_hit_q)) ||
                        fsm_q == S_WAIT_STALL);

  // levels toward the write port
  assign wp.refill_req        = fsm_q == S_REFILL_READ;
  assign wp.uncached_read_req = fsm_q == S_UNCACHE_READ;
  assign wp.write_req         = fsm_q == S_WRITE;
  assign wp.inv_req           = fsm_q == S_INVOP;
  assign wp.write_hit         = |m2_hit_q;
  assign wp.req_addr          = m2_paddr_i;
  assign wp.req_wdata         = m2_wdata_i << {m2_vaddr_i[1:0], 3'b000};
  assign wp.req_strobe        = m2_strobe_i;
  assign wp.req_wsel          = m2_hit_q;

endmodule

/* hdl/dcache_wport.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module dcache_wport import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  lsu_wport_if.wport wp,
  output logic       mem_req_o,
  output logic       mem_we_o,
  output addr_t      mem_addr_o,
  output word_t      mem_wdata_o,
  output strobe_t    mem_strobe_o,
  input  logic       mem_ack_i,
  input  word_t      mem_rdata_i
);

  typedef enum logic [1:0] {
    W_SWEEP,
    W_IDLE,
    W_MEM,
    W_FINISH
  } wport_state_e;

  wport_state_e state_q, state_d;
  idx_t         sweep_q;
  logic         rr_q;
  way_t         victim;
  logic         mem_start;
  logic         refill_done;

  assign mem_start   = wp.refill_req || wp.uncached_read_req || wp.write_req;
  assign victim      = way_t'(1) << rr_q;
  assign refill_done = (state_q == W_MEM) && mem_ack_i && wp.refill_req;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= W_SWEEP;
      sweep_q   <= '0;
      rr_q      <= 1'b0;
      mem_req_o <= 1'b0;
    end else begin
      state_q   <= state_d;
      mem_req_o <= (state_q == W_IDLE) && mem_start;
      if (state_q == W_SWEEP) begin
        sweep_q <= sweep_q + 1'b1;
      end
      if (refill_done) begin
        rr_q <= ~rr_q;
      end
    end
  end

  // bus payload, valid with the request pulse
  always_ff @(posedge clk) begin
    if (state_q == W_IDLE && mem_start) begin
      mem_we_o     <= wp.write_req;
      mem_addr_o   <= {wp.req_addr[31:2], 2'b00};
      mem_wdata_o  <= wp.req_wdata;
      mem_strobe_o <= wp.write_req ? wp.req_strobe : 4'hf;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      W_SWEEP:  if (sweep_q == '1) state_d = W_IDLE;
      W_IDLE: begin
        if (mem_start || wp.inv_req) begin
          state_d = mem_start ? W_MEM : W_FINISH;
        end
      end
      W_MEM:    if (mem_ack_i) state_d = W_FINISH;
      default:  state_d = W_IDLE;
    endcase
  end

  always_comb begin
    wp.tag_we     = '0;
    wp.tag_waddr  = wp.req_addr[`LSU_IDX_LEN+1:2];
    wp.tag_wdata  = {1'b1, wp.req_addr[31:32-`LSU_TAG_LEN]};
    wp.data_we    = '0;
    wp.data_waddr = wp.req_addr[`LSU_IDX_LEN+1:2];
    wp.data_wdata = wp.req_wdata;
    wp.read_ready = 1'b0;
    wp.rdata      = mem_rdata_i;
    case (state_q)
      W_SWEEP: begin
        wp.tag_we    = '1;
        wp.tag_waddr = sweep_q;
        wp.tag_wdata = '0;
      end
      W_IDLE: begin
        // index invalidation hits every way
        if (wp.inv_req && !mem_start) begin
          wp.tag_we    = '1;
          wp.tag_wdata = '0;
        end
      end
      W_MEM: begin
        if (mem_ack_i) begin
          wp.read_ready = wp.refill_req || wp.uncached_read_req;
          if (wp.refill_req) begin
            wp.tag_we     = victim;
            wp.data_wdata = mem_rdata_i;
            for (int w = 0; w < `LSU_WAY_CNT; w++) begin
              wp.data_we[w] = victim[w] ? 4'hf : 4'h0;
            end
          end else if (wp.write_req && wp.write_hit) begin
            for (int w = 0; w < `LSU_WAY_CNT; w++) begin
              wp.data_we[w] = wp.req_wsel[w] ? wp.req_strobe : 4'h0;
            end
          end
        end
      end
      default: ;
    endcase
  end

  // uncached reads already ended on read_ready
  assign wp.uop_ready = (state_q == W_FINISH) &&
                        (wp.refill_req || wp.write_req || wp.inv_req);

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  addr_t      ex_vaddr_i,
  input  addr_t      m1_vaddr_i,
  input  addr_t      m1_paddr_i,
  input  logic       m1_uncached_i,
  input  logic       m1_stall_i,
  input  addr_t      m2_vaddr_i,
  input  addr_t      m2_paddr_i,
  input  word_t      m2_wdata_i,
  input  strobe_t    m2_strobe_i,
  input  load_type_e m2_type_i,
  input  op_t        m2_op_i,
  input  logic       m2_valid_i,
  input  logic       m2_uncached_i,
  input  logic       m2_stall_i,
  output logic       m2_busy_o,
  output word_t      m2_rdata_o,
  output logic       m2_rvalid_o,
  output logic       mem_req_o,
  output logic       mem_we_o,
  output addr_t      mem_addr_o,
  output word_t      mem_wdata_o,
  output strobe_t    mem_strobe_o,
  input  logic       mem_ack_i,
  input  word_t      mem_rdata_i
);

  // read port to write port link
  lsu_wport_if wp ();

  dcache_rport u_rport (.*);

  dcache_wport u_wport (.*);

endmodule

/* tb/dcache_assertions.sv */
`timescale 1ns/1ps

module dcache_assertions import lsu_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       busy_i,
  input logic       rvalid_i,
  input logic       hit_valid_i,
  input way_t       hit_i,
  input logic [3:0] req_lvl_i,
  input logic       mem_req_i
);

  int unsigned fail_cnt = 0;

  a_no_rvalid_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy_i |-> !rvalid_i)
    else begin
      $error("m2_rvalid_o high while m2_busy_o is high");
      fail_cnt++;
    end

  // memory request is a single-cycle pulse
  a_mem_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i |=> !mem_req_i)
    else begin
      $error("mem_req_o held high for more than one cycle");
      fail_cnt++;
    end

  a_one_req_level: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(req_lvl_i))
    else begin
      $error("more than one write-port request level high");
      fail_cnt++;
    end

  a_hit_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    hit_valid_i |-> $onehot0(hit_i))
    else begin
      $error("m2 hit found in more than one way");
      fail_cnt++;
    end

endmodule

bind dcache_rport dcache_assertions rport_checks (
  .clk         (clk),
  .rst_n       (rst_n),
  .busy_i      (m2_busy_o),
  .rvalid_i    (m2_rvalid_o),
  .hit_valid_i (m2_valid_i),
  .hit_i       (m2_hit_q),
  .req_lvl_i   ({wp.refill_req, wp.uncached_read_req, wp.write_req, wp.inv_req}),
  .mem_req_i   (1'b0)
);

bind dcache_wport dcache_assertions wport_checks (
  .clk         (clk),
  .rst_n       (rst_n),
  .busy_i      (1'b0),
  .rvalid_i    (1'b0),
  .hit_valid_i (1'b0),
  .hit_i       (2'b00),
  .req_lvl_i   (4'b0000),
  .mem_req_i   (mem_req_o)
);

/* tb/dcache_tb.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module dcache_tb import lsu_pkg::*; ();

  localparam int    HALF_PERIOD = 20;
  localparam int    QUARTER     = 10;
  localparam int    BUSY_LIMIT  = 50;
  localparam addr_t IDLE_ADDR   = 32'h0000_0ff0;
  // reset, 300 cycle sweep wait and about forty accesses of under 20 cycles, with wide margin
  localparam int    WATCHDOG_CYCLES = 20000;

  logic       clk;
  logic       rst_n;
  addr_t      ex_vaddr_i, m1_vaddr_i, m1_paddr_i, m2_vaddr_i, m2_paddr_i;
  logic       m1_uncached_i, m1_stall_i, m2_valid_i, m2_uncached_i, m2_stall_i;
  word_t      m2_wdata_i;
  strobe_t    m2_strobe_i;
  load_type_e m2_type_i;
  op_t        m2_op_i;
  logic       m2_busy_o, m2_rvalid_o;
  word_t      m2_rdata_o;
  logic       mem_req_o, mem_we_o, mem_ack_i;
  addr_t      mem_addr_o;
  word_t      mem_wdata_o, mem_rdata_i;
  strobe_t    mem_strobe_o;

  word_t mem [0:1023];
  int    rd_cnt, wr_cnt;
  int    checks, errors, err_mark;

  dcache_top dcache_top_i (.*);

  always #(HALF_PERIOD) clk = ~clk;

  // memory model, acks each request one to four cycles later
  initial begin : mem_model
    int unsigned delay;
    int unsigned widx;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    forever begin
      @(negedge clk);
      if (mem_req_o) begin
        widx  = mem_addr_o[11:2];
        delay = $urandom % 4 + 1;
        if (mem_we_o) begin
          mem[widx] = merge_bytes(mem[widx], mem_wdata_o, mem_strobe_o);
          wr_cnt++;
        end else begin
          rd_cnt++;
        end
        repeat (delay) @(negedge clk);
        mem_ack_i   = 1'b1;
        mem_rdata_i = mem[widx];
        @(negedge clk);
        mem_ack_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("test failed");
    $finish;
  end

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, strobe_t st);
    word_t r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (st[b]) begin
        r[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return r;
  endfunction

  // expected load result from the memory word
  function automatic word_t expect_load(word_t w, logic [1:0] off, load_type_e t);
    logic [7:0]  b;
    logic [15:0] h;
    case (off)
      2'd0: b = w[7:0];
      2'd1: b = w[15:8];
      2'd2: b = w[23:16];
      default: b = w[31:24];
    endcase
    h = off[1] ? w[31:16] : w[15:0];
    case (t)
      LD_LB:   return {{24{b[7]}}, b};
      LD_LBU:  return {24'h0, b};
      LD_LH:   return {{16{h[15]}}, h};
      LD_LHU:  return {16'h0, h};
      default: return w;
    endcase
  endfunction

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == err_mark) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d mismatches", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic drive_m1(input addr_t addr, input logic unc);
    m1_vaddr_i    = addr;
    m1_paddr_i    = addr;
    m1_uncached_i = unc;
  endtask

  task automatic drive_m2(input op_t op, input addr_t addr, input load_type_e ltype,
                          input word_t wdata, input strobe_t strobe, input logic unc);
    m2_op_i       = op;
    m2_vaddr_i    = addr;
    m2_paddr_i    = addr;
    m2_type_i     = ltype;
    m2_wdata_i    = wdata;
    m2_strobe_i   = strobe;
    m2_uncached_i = unc;
    m2_valid_i    = 1'b1;
  endtask

  // one request through ex, m1 and m2, then wait for busy to fall
  task automatic access(input op_t op, input addr_t addr, input load_type_e ltype,
                        input word_t wdata, input strobe_t strobe, input logic unc,
                        output word_t rdata, output int busy_cycles);
    busy_cycles = 0;
    @(negedge clk);
    ex_vaddr_i = addr;
    @(negedge clk);
    ex_vaddr_i = IDLE_ADDR;
    drive_m1(addr, unc);
    @(negedge clk);
    drive_m1(IDLE_ADDR, 1'b0);
    drive_m2(op, addr, ltype, wdata, strobe, unc);
    #(QUARTER);
    while (m2_busy_o && busy_cycles < BUSY_LIMIT) begin
      @(negedge clk);
      #(QUARTER);
      busy_cycles++;
    end
    if (m2_busy_o) begin
      errors++;
      $display("m2_busy_o still high after %0d cycles at time %0t", BUSY_LIMIT, $time);
    end
    rdata = m2_rdata_o;
    check_count("m2_rvalid_o", int'(m2_rvalid_o), (op == `LSU_OP_READ) ? 1 : 0);
    @(negedge clk);
    m2_valid_i = 1'b0;
  endtask

  task automatic test_miss_hit();
    addr_t a;
    word_t got;
    int    cyc, reads;
    a = 32'h0000_0104;
    reads = rd_cnt;
    access(`LSU_OP_READ, a, LD_LW, '0, '0, 1'b0, got, cyc);
    check_word("miss load data", got, mem[a[11:2]]);
    check_count("miss memory reads", rd_cnt - reads, 1);
    reads = rd_cnt;
    access(`LSU_OP_READ, a, LD_LW, '0, '0, 1'b0, got, cyc);
    check_word("hit load data", got, mem[a[11:2]]);
    check_count("hit memory reads", rd_cnt - reads, 0);
    check_count("hit busy cycles", cyc, 0);
    finish_test("read miss and hit");
  endtask

  task automatic test_store_hit();
    addr_t a;
    word_t got, wd, exp;
    int    cyc, reads, writes;
    a      = 32'h0000_0104;
    wd     = $urandom;
    exp    = merge_bytes(mem[a[11:2]], wd, 4'b0110);
    writes = wr_cnt;
    access(`LSU_OP_WRITE, a, LD_LW, wd, 4'b0110, 1'b0, got, cyc);
    check_count("store memory writes", wr_cnt - writes, 1);
    check_word("memory after store", mem[a[11:2]], exp);
    reads = rd_cnt;
    access(`LSU_OP_READ, a, LD_LW, '0, '0, 1'b0, got, cyc);
    check_word("load after store", got, exp);
    check_count("load after store reads", rd_cnt - reads, 0);
    finish_test("store hit");
  endtask

  task automatic test_load_format();
    addr_t base;
    word_t got, w;
    int    cyc, reads;
    base = 32'h0000_0208;
    access(`LSU_OP_READ, base, LD_LW, '0, '0, 1'b0, got, cyc);
    w     = mem[base[11:2]];
    reads = rd_cnt;
    for (int off = 0; off < 4; off++) begin
      access(`LSU_OP_READ, base + off, LD_LB, '0, '0, 1'b0, got, cyc);
      check_word($sformatf("lb offset %0d", off), got, expect_load(w, 2'(off), LD_LB));
      access(`LSU_OP_READ, base + off, LD_LBU, '0, '0, 1'b0, got, cyc);
      check_word($sformatf("lbu offset %0d", off), got, expect_load(w, 2'(off), LD_LBU));
    end
    for (int off = 0; off < 4; off += 2) begin
      access(`LSU_OP_READ, base + off, LD_LH, '0, '0, 1'b0, got, cyc);
      check_word($sformatf("lh offset %0d", off), got, expect_load(w, 2'(off), LD_LH));
      access(`LSU_OP_READ, base + off, LD_LHU, '0, '0, 1'b0, got, cyc);
      check_word($sformatf("lhu offset %0d", off), got, expect_load(w, 2'(off), LD_LHU));
    end
    access(`LSU_OP_READ, base, LD_LW, '0, '0, 1'b0, got, cyc);
    check_word("lw offset 0", got, expect_load(w, 2'd0, LD_LW));
    check_count("format memory reads", rd_cnt - reads, 0);
    finish_test("load formatting");
  endtask

  task automatic test_uncached();
    addr_t u, s;
    word_t got, wd;
    int    cyc, reads, writes;
    u     = 32'h0000_030c;
    s     = 32'h0000_03a0;
    reads = rd_cnt;
    access(`LSU_OP_READ, u, LD_LW, '0, '0, 1'b1, got, cyc);
    check_word("first uncached load", got, mem[u[11:2]]);
    access(`LSU_OP_READ, u, LD_LW, '0, '0, 1'b1, got, cyc);
    check_word("second uncached load", got, mem[u[11:2]]);
    check_count("uncached memory reads", rd_cnt - reads, 2);
    reads = rd_cnt;
    access(`LSU_OP_READ, u, LD_LW, '0, '0, 1'b0, got, cyc);
    check_word("cached load after uncached", got, mem[u[11:2]]);
    check_count("cached load still misses", rd_cnt - reads, 1);
    wd     = $urandom;
    writes = wr_cnt;
    access(`LSU_OP_WRITE, s, LD_LW, wd, 4'hf, 1'b1, got, cyc);
    check_count("uncached store writes", wr_cnt - writes, 1);
    check_word("memory after uncached store", mem[s[11:2]], wd);
    finish_test("uncached access");
  endtask

  task automatic test_invalidate();
    addr_t a;
    word_t got;
    int    cyc, reads;
    a = 32'h0000_0104;
    access(`LSU_OP_READ, a, LD_LW, '0, '0, 1'b0, got, cyc);
    access(`LSU_OP_INV, a, LD_LW, '0, '0, 1'b0, got, cyc);
    reads = rd_cnt;
    access(`LSU_OP_READ, a, LD_LW, '0, '0, 1'b0, got, cyc);
    check_word("load after invalidation", got, mem[a[11:2]]);
    check_count("reads after invalidation", rd_cnt - reads, 1);
    finish_test("index invalidation");
  endtask

  // store in m2 with a load of the same word right behind it in m1
  task automatic test_forwarding();
    addr_t a;
    word_t got, wd, exp;
    int    cyc, writes, guard;
    logic  busy_now;
    a = 32'h0000_0208;
    access(`LSU_OP_READ, a, LD_LW, '0, '0, 1'b0, got, cyc);
    wd     = $urandom;
    exp    = merge_bytes(mem[a[11:2]], wd, 4'b1001);
    writes = wr_cnt;
    guard  = 0;
    @(negedge clk);
    ex_vaddr_i = a;
    @(negedge clk);
    drive_m1(a, 1'b0);
    @(negedge clk);
    ex_vaddr_i = IDLE_ADDR;
    drive_m2(`LSU_OP_WRITE, a, LD_LW, wd, 4'b1001, 1'b0);
    // a store always busies m2, so the load waits in m1
    m1_stall_i = 1'b1;
    do begin
      @(negedge clk);
      busy_now   = m2_busy_o;
      m1_stall_i = busy_now;
      guard++;
    end while (busy_now && guard < BUSY_LIMIT);
    if (busy_now) begin
      errors++;
      $display("store stayed busy for %0d cycles at time %0t", BUSY_LIMIT, $time);
    end
    @(negedge clk);
    drive_m1(IDLE_ADDR, 1'b0);
    drive_m2(`LSU_OP_READ, a, LD_LW, '0, '0, 1'b0);
    #(QUARTER);
    check_count("forwarded load busy", int'(m2_busy_o), 0);
    check_count("forwarded load rvalid", int'(m2_rvalid_o), 1);
    check_word("forwarded load data", m2_rdata_o, exp);
    @(negedge clk);
    m2_valid_i = 1'b0;
    check_count("forwarding store writes", wr_cnt - writes, 1);
    finish_test("back-to-back forwarding");
  endtask

  task automatic test_hit_burst();
    addr_t burst [4];
    word_t got;
    int    cyc, reads, results;
    burst   = '{32'h0000_0440, 32'h0000_0840, 32'h0000_0444, 32'h0000_0448};
    results = 0;
    // first two share a set and must land in different ways
    for (int i = 0; i < 4; i++) begin
      access(`LSU_OP_READ, burst[i], LD_LW, '0, '0, 1'b0, got, cyc);
    end
    reads = rd_cnt;
    for (int c = 0; c < 6; c++) begin
      @(negedge clk);
      ex_vaddr_i = (c < 4) ? burst[c] : IDLE_ADDR;
      drive_m1((c >= 1 && c <= 4) ? burst[c-1] : IDLE_ADDR, 1'b0);
      if (c >= 2) begin
        drive_m2(`LSU_OP_READ, burst[c-2], LD_LW, '0, '0, 1'b0);
      end
      #(QUARTER);
      if (m2_valid_i) begin
        check_count("burst busy", int'(m2_busy_o), 0);
        if (m2_rvalid_o) begin
          results++;
          check_word($sformatf("burst load %0d", c - 2), m2_rdata_o, mem[burst[c-2][11:2]]);
        end
      end
    end
    @(negedge clk);
    m2_valid_i = 1'b0;
    drive_m1(IDLE_ADDR, 1'b0);
    check_count("burst results", results, 4);
    check_count("burst memory reads", rd_cnt - reads, 0);
    finish_test("pipelined hits");
  endtask

  initial begin : main
    int unsigned assert_fails;
    void'($urandom(32'h261ce601));
    for (int i = 0; i < 1024; i++) begin
      mem[i] = $urandom;
    end
    clk           = 1'b0;
    rst_n         = 1'b0;
    ex_vaddr_i    = IDLE_ADDR;
    drive_m1(IDLE_ADDR, 1'b0);
    m1_stall_i    = 1'b0;
    m2_vaddr_i    = IDLE_ADDR;
    m2_paddr_i    = IDLE_ADDR;
    m2_wdata_i    = '0;
    m2_strobe_i   = '0;
    m2_type_i     = LD_LW;
    m2_op_i       = `LSU_OP_READ;
    m2_valid_i    = 1'b0;
    m2_uncached_i = 1'b0;
    m2_stall_i    = 1'b0;
    rd_cnt        = 0;
    wr_cnt        = 0;
    checks        = 0;
    errors        = 0;
    err_mark      = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    // tag sweep of all 256 sets
    repeat (300) @(negedge clk);
    test_miss_hit();
    test_store_hit();
    test_load_format();
    test_uncached();
    test_invalidate();
    test_forwarding();
    test_hit_burst();
    repeat (4) @(negedge clk);
    assert_fails = dcache_top_i.u_rport.rport_checks.fail_cnt +
                   dcache_top_i.u_wport.wport_checks.fail_cnt;
    $display("summary: %0d checks, %0d mismatches, %0d assertion failures, %0d reads, %0d writes",
             checks, errors, assert_fails, rd_cnt, wr_cnt);
    if (errors == 0 && assert_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_wport_if.sv
hdl/sdp_ram.sv
hdl/dcache_rport.sv
hdl/dcache_wport.sv
hdl/dcache_top.sv
tb/dcache_assertions.sv
tb/dcache_tb.sv

/* run.sh */
#!/bin/sh
# Build the dcache testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module dcache_tb -f project.f -o dcache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# let assertion errors be counted instead of stopping at the first one
out=$(./obj_dir/dcache_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
